/* common/gac_consts.svh */
// Config addresses are byte addresses with the word index in bits 9:2, and ids are 8 bits.
`ifndef GAC_CONSTS_SVH
`define GAC_CONSTS_SVH

// datapath widths
`define GAC_DATA_W       128
`define GAC_MD_W         128

// queue depths in words
`define GAC_PKT_DEPTH    256
`define GAC_MD_DEPTH     32

// action table
`define GAC_TABLE_AW     8

// module ids
`define GAC_LOCAL_MID    8'd4
`define GAC_NEXT_MID     8'd5

// configuration bus
`define GAC_CFG_AW       16
`define GAC_CFG_DW       32
`define GAC_CFG_SEL_BIT  10     // 1 selects the counter window
`define GAC_STAT_IN_PKT  8'd3
`define GAC_STAT_IN_MD   8'd5
`define GAC_STAT_OUT_PKT 8'd9

`endif

/* common/gac_pkg.sv */
// Metadata layout is fixed at 128 bits and must match the upstream parser field for field.
package gac_pkg;

	// metadata record, msb first
	typedef struct packed {
		logic       pkt_src;
		logic       pkt_des;    // 1 = to cpu
		logic [5:0] in_port;
		logic [1:0] out_type;
		logic [5:0] out_port;
		logic [2:0] prio;
		logic       discard;
		logic [19:0] rsv_a;
		logic [7:0] dmid;       // bits 87:80
		logic [21:0] rsv_b;
		logic [7:0] index;      // bits 57:50
		logic [49:0] rsv_c;
	} md_t;

	// unlisted codes behave as discard
	typedef enum logic [3:0] {
		OP_CPU_FIXED  = 4'd1,
		OP_CPU_POLL   = 4'd2,
		OP_PORT       = 4'd3,
		OP_ASSIGN_MID = 4'd4
	} action_op_e;

	// one 32-bit table word
	typedef struct packed {
		action_op_e  op;        // bits 31:28
		logic [19:0] rsv;
		logic [7:0]  arg;       // port/thread in low 6 bits, or full module id
	} action_entry_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOOKUP,
		S_EMIT_MD,
		S_STREAM
	} exec_state_e;

	typedef enum logic [1:0] {
		C_IDLE,
		C_WRITE,
		C_READ,
		C_ACK
	} cfg_state_e;

endpackage

/* common/action_lookup_if.sv */
// Lookup has a fixed one cycle latency and the table never stalls it.
`include "gac_consts.svh"

interface action_lookup_if;
	import gac_pkg::*;

	logic                     req;          // one cycle pulse
	logic [`GAC_TABLE_AW-1:0] index;
	action_entry_t            entry;
	logic                     entry_valid;  // req delayed by one cycle

	modport exec (
		output req,
		output index,
		input  entry,
		input  entry_valid
	);

	modport tbl (
		input  req,
		input  index,
		output entry,
		output entry_valid
	);

endinterface

/* verilog/sync_fifo.sv */
// Show-ahead FIFO. in_ready is registered, so it stays low for one cycle after reset.
module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [WIDTH-1:0] in_data,
	input  logic             in_valid,
	output logic             in_ready,
	output logic [WIDTH-1:0] out_data,
	output logic             out_valid,
	input  logic             out_ready
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CW-1:0]    count;
	logic [CW-1:0]    count_nxt;
	logic             push;
	logic             pop;

	// pointers wrap at DEPTH, any depth works
	function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
		return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + AW'(1);
	endfunction

	assign push      = in_valid & in_ready;
	assign pop       = out_valid & out_ready;
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];    // head word

	always_comb begin
		count_nxt = count;
		if (push && !pop) begin
			count_nxt = count + CW'(1);
		end else if (pop && !push) begin
			count_nxt = count - CW'(1);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			in_ready <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count    <= count_nxt;
			in_ready <= (count_nxt != CW'(DEPTH));    // low once full
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

endmodule

/* verilog/gac_stats.sv */
// Counters are 32 bits and wrap silently. Unknown word indices read as 0.
`include "gac_consts.svh"

module gac_stats (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pkt_in_done,
	input  logic        md_in_done,
	input  logic        pkt_out_done,
	input  logic [7:0]  sel,
	output logic [31:0] value
);
	logic [31:0] cnt [3];
	logic [2:0]  hit;

	assign hit = {pkt_out_done, md_in_done, pkt_in_done};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (hit[i]) begin
					cnt[i] <= cnt[i] + 32'd1;
				end
			end
		end
	end

	// read select
	always_comb begin
		case (sel)
			`GAC_STAT_IN_PKT:  value = cnt[0];
			`GAC_STAT_IN_MD:   value = cnt[1];
			`GAC_STAT_OUT_PKT: value = cnt[2];
			default:           value = 32'd0;
		endcase
	end

endmodule

/* action_engine/action_table.sv */
// One bus transaction at a time. Writes into the counter window (addr bit 10) are ignored.
`include "gac_consts.svh"

module action_table (
	input  logic                   clk,
	input  logic                   rst_n,
	action_lookup_if.tbl           lookup,
	input  logic                   cfg_cs,
	input  logic                   cfg_rw,      // 0 write, 1 read
	input  logic [`GAC_CFG_AW-1:0] cfg_addr,
	input  logic [`GAC_CFG_DW-1:0] cfg_wdata,
	output logic                   cfg_ack,
	output logic [`GAC_CFG_DW-1:0] cfg_rdata,
	output logic [7:0]             stat_sel,
	input  logic [31:0]            stat_value
);
	import gac_pkg::*;

	localparam int DEPTH = 1 << `GAC_TABLE_AW;

	logic [31:0]              mem [DEPTH];
	cfg_state_e               state;
	logic [`GAC_TABLE_AW-1:0] cfg_idx;
	logic                     cfg_sel;     // counters instead of table
	logic                     cfg_read;
	logic                     rd_wait;
	logic [31:0]              wr_data;
	logic [31:0]              rd_q;

	assign stat_sel = cfg_idx;

	// **************************************************************************
	// lookup port
	// **************************************************************************
	always_ff @(posedge clk) begin
		if (lookup.req) begin
			lookup.entry <= action_entry_t'(mem[lookup.index]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lookup.entry_valid <= 1'b0;
		end else begin
			lookup.entry_valid <= lookup.req;
		end
	end

	// **************************************************************************
	// config side ram access
	// **************************************************************************
	always_ff @(posedge clk) begin
		if (state == C_IDLE && cfg_cs) begin
			wr_data <= cfg_wdata;
		end
		if (state == C_WRITE && !cfg_sel) begin
			mem[cfg_idx] <= wr_data;
		end
		if (state == C_READ) begin
			rd_q <= mem[cfg_idx];
		end
	end

	// write acks 2 cycles after cs, read 3
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= C_IDLE;
			cfg_ack   <= 1'b0;
			cfg_rdata <= '0;
			cfg_idx   <= '0;
			cfg_sel   <= 1'b0;
			cfg_read  <= 1'b0;
			rd_wait   <= 1'b0;
		end else begin
			case (state)
				C_IDLE: begin
					if (cfg_cs) begin
						cfg_idx  <= cfg_addr[`GAC_TABLE_AW+1:2];
						cfg_sel  <= cfg_addr[`GAC_CFG_SEL_BIT];
						cfg_read <= cfg_rw;
						state    <= cfg_rw ? C_READ : C_WRITE;
					end
				end
				C_WRITE: begin
					state <= C_ACK;
				end
				C_READ: begin
					rd_wait <= ~rd_wait;    // ram read plus one settle cycle
					if (rd_wait) begin
						state <= C_ACK;
					end
				end
				C_ACK: begin
					if (cfg_cs) begin
						if (!cfg_ack && cfg_read) begin
							cfg_rdata <= cfg_sel ? stat_value : rd_q;
						end
						cfg_ack <= 1'b1;
					end else begin
						cfg_ack <= 1'b0;    // host released cs
						state   <= C_IDLE;
					end
				end
				default: begin
					state <= C_IDLE;
				end
			endcase
		end
	end

endmodule

/* action_engine/action_exec.sv */
// One packet in flight. Metadata and data are both 128 bits. Words ahead of a sop are dropped.
`include "gac_consts.svh"

module action_exec (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [`GAC_DATA_W-1:0] pkt_data,
	input  logic                   pkt_sop,
	input  logic                   pkt_eop,
	input  logic                   pkt_valid,
	output logic                   pkt_ready,
	input  gac_pkg::md_t           md_data,
	input  logic                   md_valid,
	output logic                   md_ready,
	action_lookup_if.exec          lookup,
	input  logic [5:0]             max_cpuid,
	output logic                   pkt_out_valid,
	input  logic                   pkt_out_ready,
	output logic [`GAC_DATA_W-1:0] pkt_out_data,
	output logic                   pkt_out_sop,
	output logic                   pkt_out_eop
);
	import gac_pkg::*;

	exec_state_e state;
	logic [5:0]  poll_id;      // rotating cpu thread
	logic        heads_ok;
	logic        is_local;
	logic        out_free;
	logic        last_out;
	md_t         md_new;

	// **************************************************************************
	// metadata rewrite
	// **************************************************************************
	function automatic md_t rewrite(input md_t md, input action_entry_t ent,
	                                input logic [5:0] poll);
		md_t r;
		r      = md;
		r.dmid = `GAC_NEXT_MID;
		case (ent.op)
			OP_CPU_FIXED, OP_CPU_POLL: begin
				r.pkt_des  = 1'b1;
				r.out_type = ent.op[1:0];
				r.out_port = (ent.op == OP_CPU_POLL) ? poll : ent.arg[5:0];
			end
			OP_PORT: begin
				r.pkt_des  = 1'b0;
				r.out_type = 2'd0;
				r.out_port = ent.arg[5:0];
			end
			OP_ASSIGN_MID: begin
				r.pkt_des  = 1'b1;
				r.out_type = 2'd0;
				r.dmid     = ent.arg;    // out_port kept
			end
			default: begin
				// discard only retargets dmid
			end
		endcase
		return r;
	endfunction

	assign heads_ok = md_valid & pkt_valid & pkt_sop;
	assign is_local = (md_data.dmid == `GAC_LOCAL_MID);
	assign out_free = ~pkt_out_valid | pkt_out_ready;
	assign last_out = pkt_out_valid & pkt_out_eop;
	assign md_new   = rewrite(md_data, lookup.entry, poll_id);

	assign lookup.req   = (state == S_IDLE) & heads_ok & is_local;
	assign lookup.index = md_data.index;

	// md pops when its word leaves
	assign md_ready = (state == S_EMIT_MD) & pkt_out_ready;

	always_comb begin
		case (state)
			S_IDLE:    pkt_ready = ~pkt_sop;          // flush stray words
			S_EMIT_MD: pkt_ready = pkt_out_ready;     // first word replaces md
			S_STREAM:  pkt_ready = out_free & ~last_out;
			default:   pkt_ready = 1'b0;
		endcase
	end

	// **************************************************************************
	// main fsm
	// **************************************************************************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state         <= S_IDLE;
			poll_id       <= '0;
			pkt_out_valid <= 1'b0;
			pkt_out_data  <= '0;
			pkt_out_sop   <= 1'b0;
			pkt_out_eop   <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (heads_ok && is_local) begin
						state <= S_LOOKUP;
					end else if (heads_ok) begin
						pkt_out_data  <= md_data;    // bypass passes md unchanged
						pkt_out_sop   <= 1'b1;
						pkt_out_eop   <= 1'b0;
						pkt_out_valid <= 1'b1;
						state         <= S_EMIT_MD;
					end
				end
				S_LOOKUP: begin
					if (lookup.entry_valid) begin
						pkt_out_data  <= md_new;
						pkt_out_sop   <= 1'b1;
						pkt_out_eop   <= 1'b0;
						pkt_out_valid <= 1'b1;
						if (lookup.entry.op == OP_CPU_POLL) begin
							poll_id <= ({1'b0, poll_id} + 7'd1 < {1'b0, max_cpuid}) ?
							           poll_id + 6'd1 : 6'd0;
						end
						state <= S_EMIT_MD;
					end
				end
				S_EMIT_MD: begin
					if (pkt_out_ready) begin
						pkt_out_data <= pkt_data;    // head is the sop word
						pkt_out_sop  <= 1'b0;
						pkt_out_eop  <= pkt_eop;
						state        <= S_STREAM;
					end
				end
				S_STREAM: begin
					if (out_free && last_out) begin
						pkt_out_valid <= 1'b0;
						state         <= S_IDLE;
					end else if (out_free) begin
						pkt_out_valid <= pkt_valid;  // bubble if queue ran dry
						if (pkt_valid) begin
							pkt_out_data <= pkt_data;
							pkt_out_eop  <= pkt_eop;
						end
					end
				end
				default: begin
					pkt_out_valid <= 1'b0;
					state         <= S_IDLE;
				end
			endcase
		end
	end

endmodule

/* verilog/gac_top.sv */
// Metadata and packet words share one output stream, the metadata word first and marked with sop.
`include "gac_consts.svh"

module gac_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic [5:0]             max_cpuid,
	input  logic                   pkt_in_valid,
	output logic                   pkt_in_ready,
	input  logic [`GAC_DATA_W-1:0] pkt_in_data,
	input  logic                   pkt_in_sop,
	input  logic                   pkt_in_eop,
	input  logic                   md_in_valid,
	output logic                   md_in_ready,
	input  logic [`GAC_MD_W-1:0]   md_in_data,
	output logic                   pkt_out_valid,
	input  logic                   pkt_out_ready,
	output logic [`GAC_DATA_W-1:0] pkt_out_data,
	output logic                   pkt_out_sop,
	output logic                   pkt_out_eop,
	input  logic                   cfg_cs,
	input  logic                   cfg_rw,
	input  logic [`GAC_CFG_AW-1:0] cfg_addr,
	input  logic [`GAC_CFG_DW-1:0] cfg_wdata,
	output logic                   cfg_ack,
	output logic [`GAC_CFG_DW-1:0] cfg_rdata
);
	logic [`GAC_DATA_W+1:0] pq_data;    // {eop, sop, data}
	logic                   pq_valid;
	logic                   pq_ready;
	logic [`GAC_MD_W-1:0]   mq_data;
	logic                   mq_valid;
	logic                   mq_ready;
	logic [7:0]             stat_sel;
	logic [31:0]            stat_value;

	action_lookup_if lookup_if ();

	sync_fifo #(.WIDTH(`GAC_DATA_W + 2), .DEPTH(`GAC_PKT_DEPTH)) u_pkt_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   ({pkt_in_eop, pkt_in_sop, pkt_in_data}),
		.in_valid  (pkt_in_valid),
		.in_ready  (pkt_in_ready),
		.out_data  (pq_data),
		.out_valid (pq_valid),
		.out_ready (pq_ready)
	);

	sync_fifo #(.WIDTH(`GAC_MD_W), .DEPTH(`GAC_MD_DEPTH)) u_md_q (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_data   (md_in_data),
		.in_valid  (md_in_valid),
		.in_ready  (md_in_ready),
		.out_data  (mq_data),
		.out_valid (mq_valid),
		.out_ready (mq_ready)
	);

	action_table u_table (
		.clk        (clk),
		.rst_n      (rst_n),
		.lookup     (lookup_if.tbl),
		.cfg_cs     (cfg_cs),
		.cfg_rw     (cfg_rw),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_ack    (cfg_ack),
		.cfg_rdata  (cfg_rdata),
		.stat_sel   (stat_sel),
		.stat_value (stat_value)
	);

	action_exec u_exec (
		.clk           (clk),
		.rst_n         (rst_n),
		.pkt_data      (pq_data[`GAC_DATA_W-1:0]),
		.pkt_sop       (pq_data[`GAC_DATA_W]),
		.pkt_eop       (pq_data[`GAC_DATA_W+1]),
		.pkt_valid     (pq_valid),
		.pkt_ready     (pq_ready),
		.md_data       (mq_data),
		.md_valid      (mq_valid),
		.md_ready      (mq_ready),
		.lookup        (lookup_if.exec),
		.max_cpuid     (max_cpuid),
		.pkt_out_valid (pkt_out_valid),
		.pkt_out_ready (pkt_out_ready),
		.pkt_out_data  (pkt_out_data),
		.pkt_out_sop   (pkt_out_sop),
		.pkt_out_eop   (pkt_out_eop)
	);

	// a packet counts on its accepted eop word
	gac_stats u_stats (
		.clk          (clk),
		.rst_n        (rst_n),
		.pkt_in_done  (pkt_in_valid & pkt_in_ready & pkt_in_eop),
		.md_in_done   (md_in_valid & md_in_ready),
		.pkt_out_done (pkt_out_valid & pkt_out_ready & pkt_out_eop),
		.sel          (stat_sel),
		.value        (stat_value)
	);

endmodule

/* tb/tb_gac.sv */
// Needs a simulator with timing support. Table reads only touch entries written during the run.
`include "gac_consts.svh"

module tb_gac;
	localparam int HALF_PERIOD = 20;
	localparam int TOTAL_PKTS  = 43;    // 3 + 5 + 5 + 30 packets over all tests

	logic                   clk;
	logic                   rst_n;
	logic [5:0]             max_cpuid;
	logic                   pkt_in_valid;
	logic                   pkt_in_ready;
	logic [`GAC_DATA_W-1:0] pkt_in_data;
	logic                   pkt_in_sop;
	logic                   pkt_in_eop;
	logic                   md_in_valid;
	logic                   md_in_ready;
	logic [`GAC_MD_W-1:0]   md_in_data;
	logic                   pkt_out_valid;
	logic                   pkt_out_ready;
	logic [`GAC_DATA_W-1:0] pkt_out_data;
	logic                   pkt_out_sop;
	logic                   pkt_out_eop;
	logic                   cfg_cs;
	logic                   cfg_rw;
	logic [`GAC_CFG_AW-1:0] cfg_addr;
	logic [`GAC_CFG_DW-1:0] cfg_wdata;
	logic                   cfg_ack;
	logic [`GAC_CFG_DW-1:0] cfg_rdata;

	logic [129:0] exp_q [$];          // {eop, sop, word} in output order
	logic [129:0] exp_w;
	logic [31:0]  tbl_model [256];
	logic [5:0]   poll_model;
	int           errors = 0;
	int           checks = 0;
	int           tests_run = 0;
	int           err_base = 0;
	int           sent_pkts = 0;
	int           out_pkts = 0;
	bit           rand_ready = 1'b0;

	gac_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// output back-pressure is random only in the stress test
	initial begin
		pkt_out_ready = 1'b0;
		forever begin
			@(negedge clk);
			pkt_out_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
		end
	end

	initial begin
		repeat (200 * TOTAL_PKTS + 2000) @(posedge clk);
		$display("timeout: traffic or bus handshake stalled");
		$display("Simulation failed");
		$finish;
	end

	// **************************************************************************
	// checking and reference model
	// **************************************************************************
	task automatic check_value(input string name, input logic [127:0] exp,
	                           input logic [127:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	function automatic logic [127:0] rand_word();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	// bit slices of pkt_des 126, out_type 119:118, out_port 117:112, dmid 87:80, index 57:50
	function automatic logic [127:0] expect_md(input logic [127:0] md);
		logic [127:0] r;
		logic [31:0]  ent;
		r = md;
		if (md[87:80] == `GAC_LOCAL_MID) begin
			ent      = tbl_model[md[57:50]];
			r[87:80] = `GAC_NEXT_MID;
			case (ent[31:28])
				4'd1, 4'd2: begin
					r[126]     = 1'b1;
					r[119:118] = ent[29:28];
					r[117:112] = (ent[31:28] == 4'd2) ? poll_model : ent[5:0];
					if (ent[31:28] == 4'd2) begin
						if (int'(poll_model) + 1 >= int'(max_cpuid)) poll_model = 6'd0;
						else poll_model = poll_model + 6'd1;
					end
				end
				4'd3: begin
					r[126]     = 1'b0;
					r[119:118] = 2'd0;
					r[117:112] = ent[5:0];
				end
				4'd4: begin
					r[126]     = 1'b1;
					r[119:118] = 2'd0;
					r[87:80]   = ent[7:0];
				end
				default: begin
				end
			endcase
		end
		return r;
	endfunction

	always @(posedge clk) begin
		if (rst_n && pkt_out_valid && pkt_out_ready) begin
			if (exp_q.size() == 0) begin
				$display("t=%0t: output word seen with no packet outstanding", $time);
				errors++;
			end else begin
				exp_w = exp_q.pop_front();
				check_value("pkt_out_data", exp_w[127:0], pkt_out_data);
				check_value("pkt_out_sop", 128'(exp_w[128]), 128'(pkt_out_sop));
				check_value("pkt_out_eop", 128'(exp_w[129]), 128'(pkt_out_eop));
				if (pkt_out_eop) out_pkts++;
			end
		end
	end

	// **************************************************************************
	// stimulus
	// **************************************************************************
	task automatic push_md(input logic [127:0] md);
		md_in_data  = md;
		md_in_valid = 1'b1;
		while (!md_in_ready) @(negedge clk);
		@(negedge clk);
		md_in_valid = 1'b0;
	endtask

	task automatic push_word(input logic sop, input logic eop, input logic [127:0] data);
		pkt_in_data  = data;
		pkt_in_sop   = sop;
		pkt_in_eop   = eop;
		pkt_in_valid = 1'b1;
		while (!pkt_in_ready) @(negedge clk);
		@(negedge clk);
		pkt_in_valid = 1'b0;
	endtask

	task automatic send_packet(input logic [7:0] dmid, input logic [7:0] index,
	                           input int nwords, input bit gaps);
		logic [127:0] md;
		logic [127:0] w;
		md        = rand_word();
		md[87:80] = dmid;
		md[57:50] = index;
		exp_q.push_back({1'b0, 1'b1, expect_md(md)});
		push_md(md);
		for (int i = 0; i < nwords; i++) begin
			w = rand_word();
			exp_q.push_back({i == nwords - 1, 1'b0, w});
			push_word(i == 0, i == nwords - 1, w);
			if (gaps) repeat ($urandom % 3) @(negedge clk);
		end
		sent_pkts++;
	endtask

	// host side of the bus holds cs until ack
	task automatic cfg_access(input logic rw, input logic [15:0] addr,
	                          input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		cfg_rw    = rw;
		cfg_addr  = addr;
		cfg_wdata = wdata;
		cfg_cs    = 1'b1;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!cfg_ack && n < 16);
		checks++;
		assert (cfg_ack && n == (rw ? 4 : 3)) else begin
			$display("t=%0t: bus ack at address %h came after %0d cycles", $time, addr, n);
			errors++;
		end
		rdata  = cfg_rdata;
		cfg_cs = 1'b0;
		@(negedge clk);
		checks++;
		assert (!cfg_ack) else begin
			$display("t=%0t: bus ack still high a cycle after cs dropped", $time);
			errors++;
		end
	endtask

	task automatic write_entry(input logic [7:0] idx, input logic [31:0] data);
		logic [31:0] dummy;
		tbl_model[idx] = data;
		cfg_access(1'b0, {5'd0, 1'b0, idx, 2'b00}, data, dummy);
	endtask

	task automatic read_check(input logic sel, input logic [7:0] idx, input logic [31:0] exp);
		logic [31:0] rd;
		cfg_access(1'b1, {5'd0, sel, idx, 2'b00}, 32'd0, rd);
		check_value("cfg_rdata", 128'(exp), 128'(rd));
	endtask

	task automatic wait_drain();
		while (out_pkts != sent_pkts) @(negedge clk);
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("t=%0t: %0d expected words never came out", $time, exp_q.size());
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %-12s %s, %0d errors", name, (errors == err_base) ? "ok" : "FAILED",
		         errors - err_base);
		err_base = errors;
	endtask

	initial begin
		logic [7:0]  dmid;
		logic [7:0]  idx;
		void'($urandom(32'h960e8a8f));
		rst_n        = 1'b0;
		max_cpuid    = 6'd3;
		poll_model   = 6'd0;
		pkt_in_valid = 1'b0;
		pkt_in_data  = '0;
		pkt_in_sop   = 1'b0;
		pkt_in_eop   = 1'b0;
		md_in_valid  = 1'b0;
		md_in_data   = '0;
		cfg_cs       = 1'b0;
		cfg_rw       = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		repeat (4) @(negedge clk);
		check_value("pkt_out_valid", 128'(0), 128'(pkt_out_valid));
		check_value("cfg_ack", 128'(0), 128'(cfg_ack));
		check_value("pkt_in_ready", 128'(0), 128'(pkt_in_ready));
		check_value("md_in_ready", 128'(0), 128'(md_in_ready));
		rst_n = 1'b1;
		@(negedge clk);
		check_value("pkt_in_ready", 128'(1), 128'(pkt_in_ready));
		check_value("md_in_ready", 128'(1), 128'(md_in_ready));

		send_packet(8'h09, 8'h00, 1, 1'b0);    // foreign module ids pass through
		send_packet(8'h00, 8'h11, 2, 1'b0);
		send_packet(8'hff, 8'h01, 5, 1'b0);
		wait_drain();
		end_test("bypass");

		write_entry(8'd1, {4'd1, 20'd0, 8'h2a});
		write_entry(8'd2, {4'd2, 20'd0, 8'h3f});
		write_entry(8'd3, {4'd3, 20'h12345, 8'h13});
		write_entry(8'd4, {4'd4, 20'd0, 8'h77});
		write_entry(8'd5, {4'hf, 20'd0, 8'h33});
		write_entry(8'd6, {4'd0, 20'd0, 8'h01});
		for (int i = 16; i < 48; i++) write_entry(8'(i), $urandom);
		for (int i = 1; i < 48; i++) begin
			if (i <= 6 || i >= 16) read_check(1'b0, 8'(i), tbl_model[i]);
		end
		end_test("table_rw");

		for (int i = 1; i <= 6; i++) begin
			if (i != 2) send_packet(`GAC_LOCAL_MID, 8'(i), 3, 1'b0);
		end
		wait_drain();
		end_test("opcodes");

		repeat (5) send_packet(`GAC_LOCAL_MID, 8'd2, 2, 1'b0);    // threads 0 1 2 0 1
		wait_drain();
		end_test("polling");

		rand_ready = 1'b1;
		repeat (30) begin
			dmid = (($urandom % 3) == 0) ? 8'h20 : `GAC_LOCAL_MID;
			idx  = (($urandom % 2) == 0) ? 8'(16 + $urandom % 32) : 8'(1 + $urandom % 6);
			send_packet(dmid, idx, int'(1 + $urandom % 6), 1'b1);
			repeat ($urandom % 4) @(negedge clk);
		end
		wait_drain();
		rand_ready = 1'b0;
		end_test("backpressure");

		read_check(1'b1, `GAC_STAT_IN_PKT, 32'(sent_pkts));
		read_check(1'b1, `GAC_STAT_IN_MD, 32'(sent_pkts));
		read_check(1'b1, `GAC_STAT_OUT_PKT, 32'(sent_pkts));
		read_check(1'b1, 8'd7, 32'd0);    // no counter here
		end_test("counters");

		$display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+common
common/gac_pkg.sv
common/action_lookup_if.sv
verilog/sync_fifo.sv
verilog/gac_stats.sv
action_engine/action_table.sv
action_engine/action_exec.sv
verilog/gac_top.sv
tb/tb_gac.sv

/* Makefile */
TOP = tb_gac

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
